/* logic/rename_defs.svh */
`ifndef RENAME_DEFS_SVH
`define RENAME_DEFS_SVH

// ======================================================================
// Rename unit sizes
// ======================================================================

// Lanes per decode group
`define RN_FETCH_W      2
// Register file sizes
`define RN_ARCH_REGS    32
`define RN_PHYS_REGS    48
// Issue-queue entries handed out as credits
`define RN_IQ_CREDITS   8

// Derived widths
`define RN_ARCH_W       5
`define RN_PHYS_W       6
// Per-group lane count, 0 to RN_FETCH_W
`define RN_GROUP_CNT_W  2
// Free register count, 0 to RN_PHYS_REGS
`define RN_FREE_CNT_W   7

`endif

/* logic/rename_pkg.sv */
`include "rename_defs.svh"

package rename_pkg;

    // Register indices
    typedef logic [`RN_ARCH_W-1:0] arch_reg_t;
    typedef logic [`RN_PHYS_W-1:0] phys_reg_t;

    // ==================================================================
    // Decoded instruction, one lane
    // ==================================================================
    typedef struct packed {
        logic       valid;
        logic [5:0] opcode;
        logic [5:0] alu_func;
        arch_reg_t  rs1;
        logic       rs1_valid;
        arch_reg_t  rs2;
        logic       rs2_valid;
        arch_reg_t  rd;
        logic       rd_valid;
        logic [31:0] imm;
        logic [31:0] pc;
        logic       is_alu;
        logic       is_load;
        logic       is_store;
        logic       is_branch;
        logic       is_cas;
    } dec_uop_t;

    typedef dec_uop_t [`RN_FETCH_W-1:0] dec_group_t;

    // ==================================================================
    // Renamed instruction, one lane
    // ==================================================================
    typedef struct packed {
        logic       valid;
        logic [5:0] opcode;
        logic [5:0] alu_func;
        phys_reg_t  prs1;
        logic       prs1_valid;
        phys_reg_t  prs2;
        logic       prs2_valid;
        phys_reg_t  prd;
        logic       prd_valid;
        // Mapping replaced by prd, freed when this instruction commits
        phys_reg_t  old_prd;
        arch_reg_t  arch_rd;
        logic [31:0] imm;
        logic [31:0] pc;
        logic       is_alu;
        logic       is_load;
        logic       is_store;
        logic       is_branch;
        logic       is_cas;
    } ren_uop_t;

    typedef ren_uop_t [`RN_FETCH_W-1:0] ren_group_t;

    // Commit port, one retiring instruction per cycle
    typedef struct packed {
        logic      valid;
        arch_reg_t arch_rd;
        phys_reg_t old_prd;
    } commit_t;

endpackage

/* logic/free_list.sv */
`timescale 1ns/1ps
`include "rename_defs.svh"

module free_list #(
    parameter int PHYS_REGS = `RN_PHYS_REGS
) (
    input  logic                                     clk,
    input  logic                                     reset,
    // Allocation side
    input  logic [`RN_FETCH_W-1:0]                   alloc_take,
    output rename_pkg::phys_reg_t [`RN_FETCH_W-1:0]  offer_preg,
    output logic [`RN_FETCH_W-1:0]                   offer_valid,
    // Release side
    input  rename_pkg::commit_t                      commit,
    output logic [`RN_FREE_CNT_W-1:0]                free_count
);

    // One bit per physical register, set while free
    logic [PHYS_REGS-1:0] free_mask;
    logic [PHYS_REGS-1:0] scan_mask;
    logic [PHYS_REGS-1:0] free_next;

    // ==================================================================
    // Offers
    // ==================================================================

    // Lane 0 gets the lowest free index, lane 1 the next one up
    always_comb begin
        scan_mask   = free_mask;
        offer_valid = '0;
        offer_preg  = '0;
        for (int l = 0; l < `RN_FETCH_W; l++) begin
            // Physical 0 backs x0 and is never handed out
            for (int i = 1; i < PHYS_REGS; i++) begin
                if (scan_mask[i] && !offer_valid[l]) begin
                    offer_valid[l] = 1'b1;
                    offer_preg[l]  = rename_pkg::phys_reg_t'(i);
                    scan_mask[i]   = 1'b0;
                end
            end
        end
    end

    // Population count for status
    always_comb begin
        free_count = '0;
        for (int i = 0; i < PHYS_REGS; i++) begin
            free_count = free_count + `RN_FREE_CNT_W'(free_mask[i]);
        end
    end

    // ==================================================================
    // Mask update
    // ==================================================================

    always_comb begin
        free_next = free_mask;
        // Taken registers leave the pool
        for (int l = 0; l < `RN_FETCH_W; l++) begin
            if (alloc_take[l] && offer_valid[l]) begin
                free_next[offer_preg[l]] = 1'b0;
            end
        end
        // Retiring instruction returns the mapping it replaced
        // old_prd 0 means x0 or no destination
        if (commit.valid && commit.old_prd != '0) begin
            free_next[commit.old_prd] = 1'b1;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            // Architectural state sits in 0..ARCH_REGS-1 after reset
            for (int i = 0; i < PHYS_REGS; i++) begin
                free_mask[i] <= (i >= `RN_ARCH_REGS);
            end
        end else begin
            free_mask <= free_next;
        end
    end

    // ==================================================================
    // Checks
    // ==================================================================

    // Rename stage only takes what was offered
    a_take_offered: assert property (
        @(posedge clk) disable iff (reset)
        (alloc_take & ~offer_valid) == '0
    );

    // Double free points at a wrong old_prd from commit
    a_no_double_free: assert property (
        @(posedge clk) disable iff (reset)
        (commit.valid && commit.old_prd != '0) |-> !free_mask[commit.old_prd]
    );

endmodule

/* logic/rename_table.sv */
`timescale 1ns/1ps
`include "rename_defs.svh"

module rename_table #(
    parameter int ARCH_REGS = `RN_ARCH_REGS
) (
    input  logic                                          clk,
    input  logic                                          reset,
    // Source lookups, index 0 is rs1 and index 1 is rs2
    input  rename_pkg::arch_reg_t [`RN_FETCH_W-1:0][1:0]  src_arch,
    output rename_pkg::phys_reg_t [`RN_FETCH_W-1:0][1:0]  src_preg,
    // Destination lookups for old_prd
    input  rename_pkg::arch_reg_t [`RN_FETCH_W-1:0]       dst_arch,
    output rename_pkg::phys_reg_t [`RN_FETCH_W-1:0]       dst_old_preg,
    // New mappings
    input  logic [`RN_FETCH_W-1:0]                        wr_en,
    input  rename_pkg::arch_reg_t [`RN_FETCH_W-1:0]       wr_arch,
    input  rename_pkg::phys_reg_t [`RN_FETCH_W-1:0]       wr_preg
);

    // Speculative map, one entry per architectural register
    rename_pkg::phys_reg_t map_q [ARCH_REGS];

    // ==================================================================
    // Combinational reads
    // ==================================================================

    // x0 reads as physical 0 whatever the entry holds
    always_comb begin
        for (int l = 0; l < `RN_FETCH_W; l++) begin
            for (int s = 0; s < 2; s++) begin
                src_preg[l][s] = (src_arch[l][s] == '0) ? '0 : map_q[src_arch[l][s]];
            end
            dst_old_preg[l] = (dst_arch[l] == '0) ? '0 : map_q[dst_arch[l]];
        end
    end

    // ==================================================================
    // Writes
    // ==================================================================

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            // Identity map
            for (int i = 0; i < ARCH_REGS; i++) begin
                map_q[i] <= rename_pkg::phys_reg_t'(i);
            end
        end else begin
            // Higher lane is younger, so its write lands last
            for (int l = 0; l < `RN_FETCH_W; l++) begin
                if (wr_en[l]) begin
                    map_q[wr_arch[l]] <= wr_preg[l];
                end
            end
        end
    end

    // ==================================================================
    // Checks
    // ==================================================================

    // Stage must filter x0 destinations before writing
    for (genvar l = 0; l < `RN_FETCH_W; l++) begin : g_chk
        a_no_x0_write: assert property (
            @(posedge clk) disable iff (reset)
            wr_en[l] |-> wr_arch[l] != '0
        );
    end

endmodule

/* logic/rename_stage.sv */
`timescale 1ns/1ps
`include "rename_defs.svh"

module rename_stage #(
    parameter int IQ_CREDITS = `RN_IQ_CREDITS
) (
    input  logic                                          clk,
    input  logic                                          reset,
    // Decode side
    input  rename_pkg::dec_group_t                        dec_group,
    input  logic                                          dec_in_valid,
    output logic                                          dec_ready,
    // Issue-queue side
    output rename_pkg::ren_group_t                        ren_group,
    output logic                                          ren_out_valid,
    input  logic [`RN_GROUP_CNT_W-1:0]                    credit_return,
    // Rename table
    output rename_pkg::arch_reg_t [`RN_FETCH_W-1:0][1:0]  src_arch,
    input  rename_pkg::phys_reg_t [`RN_FETCH_W-1:0][1:0]  src_preg,
    output rename_pkg::arch_reg_t [`RN_FETCH_W-1:0]       dst_arch,
    input  rename_pkg::phys_reg_t [`RN_FETCH_W-1:0]       dst_old_preg,
    output logic [`RN_FETCH_W-1:0]                        wr_en,
    output rename_pkg::arch_reg_t [`RN_FETCH_W-1:0]       wr_arch,
    output rename_pkg::phys_reg_t [`RN_FETCH_W-1:0]       wr_preg,
    // Free list
    output logic [`RN_FETCH_W-1:0]                        alloc_take,
    input  rename_pkg::phys_reg_t [`RN_FETCH_W-1:0]       offer_preg,
    input  logic [`RN_FETCH_W-1:0]                        offer_valid
);

    localparam int CRED_W = $clog2(IQ_CREDITS + 1);

    logic [`RN_FETCH_W-1:0]     need_dst;
    logic [`RN_GROUP_CNT_W-1:0] n_valid;
    logic [CRED_W-1:0]          credits_q;
    logic                       fire;
    rename_pkg::ren_group_t     ren_next;

    // ==================================================================
    // Flow control
    // ==================================================================

    // A lane allocates only for a real, non-x0 destination
    always_comb begin
        n_valid = '0;
        for (int l = 0; l < `RN_FETCH_W; l++) begin
            need_dst[l] = dec_group[l].valid && dec_group[l].rd_valid
                          && (dec_group[l].rd != '0);
            n_valid     = n_valid + `RN_GROUP_CNT_W'(dec_group[l].valid);
        end
    end

    // Every needing lane has an offer, and the issue queue has room
    assign dec_ready = ((need_dst & ~offer_valid) == '0)
                       && (credits_q >= CRED_W'(n_valid));
    assign fire      = dec_in_valid && dec_ready;

    // Offers are consumed only on a transfer
    assign alloc_take = fire ? need_dst : '0;

    // ==================================================================
    // Table access
    // ==================================================================

    always_comb begin
        for (int l = 0; l < `RN_FETCH_W; l++) begin
            src_arch[l][0] = dec_group[l].rs1;
            src_arch[l][1] = dec_group[l].rs2;
            dst_arch[l]    = dec_group[l].rd;
            wr_arch[l]     = dec_group[l].rd;
            wr_preg[l]     = offer_preg[l];
        end
    end

    // Same mask as the allocation
    assign wr_en = alloc_take;

    // ==================================================================
    // Renaming with intra-group forwarding
    // ==================================================================

    always_comb begin
        for (int l = 0; l < `RN_FETCH_W; l++) begin
            ren_next[l].valid      = dec_group[l].valid;
            ren_next[l].opcode     = dec_group[l].opcode;
            ren_next[l].alu_func   = dec_group[l].alu_func;
            ren_next[l].imm        = dec_group[l].imm;
            ren_next[l].pc         = dec_group[l].pc;
            ren_next[l].is_alu     = dec_group[l].is_alu;
            ren_next[l].is_load    = dec_group[l].is_load;
            ren_next[l].is_store   = dec_group[l].is_store;
            ren_next[l].is_branch  = dec_group[l].is_branch;
            ren_next[l].is_cas     = dec_group[l].is_cas;
            ren_next[l].arch_rd    = dec_group[l].rd;
            ren_next[l].prs1_valid = dec_group[l].rs1_valid;
            ren_next[l].prs2_valid = dec_group[l].rs2_valid;
            ren_next[l].prd_valid  = need_dst[l];
            ren_next[l].prd        = need_dst[l] ? offer_preg[l] : '0;
            // Table view first
            ren_next[l].prs1       = src_preg[l][0];
            ren_next[l].prs2       = src_preg[l][1];
            ren_next[l].old_prd    = dst_old_preg[l];
            // Older lanes in the group override, nearest one last
            for (int j = 0; j < l; j++) begin
                if (need_dst[j]) begin
                    if (dec_group[l].rs1 == dec_group[j].rd)
                        ren_next[l].prs1 = offer_preg[j];
                    if (dec_group[l].rs2 == dec_group[j].rd)
                        ren_next[l].prs2 = offer_preg[j];
                    if (dec_group[l].rd == dec_group[j].rd)
                        ren_next[l].old_prd = offer_preg[j];
                end
            end
            // Unused operands read as 0
            if (!dec_group[l].rs1_valid)
                ren_next[l].prs1 = '0;
            if (!dec_group[l].rs2_valid)
                ren_next[l].prs2 = '0;
            if (!need_dst[l])
                ren_next[l].old_prd = '0;
        end
    end

    // ==================================================================
    // Output register and credits
    // ==================================================================

    // Payload loads on transfer only
    always_ff @(posedge clk) begin
        if (fire) begin
            ren_group <= ren_next;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ren_out_valid <= 1'b0;
            credits_q     <= CRED_W'(IQ_CREDITS);
        end else begin
            // One pulse per accepted group
            ren_out_valid <= fire;
            credits_q     <= credits_q - (fire ? CRED_W'(n_valid) : '0)
                             + CRED_W'(credit_return);
        end
    end

    // Issue queue returns no more than it was given
    a_credit_bound: assert property (
        @(posedge clk) disable iff (reset)
        credits_q <= CRED_W'(IQ_CREDITS)
    );

endmodule

/* logic/rename_unit.sv */
`timescale 1ns/1ps
`include "rename_defs.svh"

module rename_unit (
    input  logic                              clk,
    input  logic                              reset,
    // Decode
    input  rename_pkg::dec_group_t            dec_group,
    input  logic                              dec_in_valid,
    output logic                              dec_ready,
    // Issue queue
    output rename_pkg::ren_group_t            ren_group,
    output logic                              ren_out_valid,
    input  logic [`RN_GROUP_CNT_W-1:0]        credit_return,
    // Retirement
    input  rename_pkg::commit_t               commit,
    output logic [`RN_FREE_CNT_W-1:0]         free_count
);

    // ==================================================================
    // Stage to table
    // ==================================================================
    rename_pkg::arch_reg_t [`RN_FETCH_W-1:0][1:0] src_arch;
    rename_pkg::phys_reg_t [`RN_FETCH_W-1:0][1:0] src_preg;
    rename_pkg::arch_reg_t [`RN_FETCH_W-1:0]      dst_arch;
    rename_pkg::phys_reg_t [`RN_FETCH_W-1:0]      dst_old_preg;
    logic [`RN_FETCH_W-1:0]                       wr_en;
    rename_pkg::arch_reg_t [`RN_FETCH_W-1:0]      wr_arch;
    rename_pkg::phys_reg_t [`RN_FETCH_W-1:0]      wr_preg;

    // Stage to free list
    logic [`RN_FETCH_W-1:0]                       alloc_take;
    rename_pkg::phys_reg_t [`RN_FETCH_W-1:0]      offer_preg;
    logic [`RN_FETCH_W-1:0]                       offer_valid;

    rename_stage #(.IQ_CREDITS(`RN_IQ_CREDITS)) u_stage (
        .clk, .reset,
        .dec_group, .dec_in_valid, .dec_ready,
        .ren_group, .ren_out_valid, .credit_return,
        .src_arch, .src_preg, .dst_arch, .dst_old_preg,
        .wr_en, .wr_arch, .wr_preg,
        .alloc_take, .offer_preg, .offer_valid
    );

    rename_table #(.ARCH_REGS(`RN_ARCH_REGS)) u_table (
        .clk, .reset,
        .src_arch, .src_preg, .dst_arch, .dst_old_preg,
        .wr_en, .wr_arch, .wr_preg
    );

    // Commit goes straight to the pool
    free_list #(.PHYS_REGS(`RN_PHYS_REGS)) u_free_list (
        .clk, .reset,
        .alloc_take, .offer_preg, .offer_valid,
        .commit, .free_count
    );

endmodule

/* test/rename_model.sv */
`timescale 1ns/1ps
`include "rename_defs.svh"

module rename_model (
    input  logic                        clk,
    input  logic                        reset,
    input  rename_pkg::dec_group_t      dec_group,
    input  logic                        dec_in_valid,
    input  logic                        dec_ready,
    input  rename_pkg::ren_group_t      ren_group,
    input  logic                        ren_out_valid,
    input  logic [`RN_GROUP_CNT_W-1:0]  credit_return,
    input  rename_pkg::commit_t         commit,
    input  logic [`RN_FREE_CNT_W-1:0]   free_count,
    output int                          errors
);

    // Shadow state
    rename_pkg::phys_reg_t [`RN_ARCH_REGS-1:0] shadow_map;
    logic [`RN_PHYS_REGS-1:0]                  shadow_free;
    int                                        credits;
    // Instructions seen at the output and not yet returned
    int                                        in_flight;
    rename_pkg::ren_group_t                    exp_group;

    // Per-cycle view of the offered group
    rename_pkg::phys_reg_t [`RN_FETCH_W-1:0]   pick;
    logic [`RN_FETCH_W-1:0]                    has_pick;
    logic [`RN_FETCH_W-1:0]                    needs;
    int                                        lanes;
    logic                                      exp_ready;

    initial errors = 0;

    function automatic int count_sent(input rename_pkg::ren_group_t g);
        int n;
        n = 0;
        for (int l = 0; l < `RN_FETCH_W; l++) begin
            n += int'(g[l].valid);
        end
        return n;
    endfunction

    // ==================================================================
    // Expected handshake
    // ==================================================================
    always_comb begin
        int k;
        k        = 0;
        has_pick = '0;
        pick     = '0;
        needs    = '0;
        lanes    = 0;
        // Lowest free registers in lane order, skipping physical 0
        for (int i = 1; i < `RN_PHYS_REGS; i++) begin
            if (shadow_free[i] && k < `RN_FETCH_W) begin
                pick[k]     = rename_pkg::phys_reg_t'(i);
                has_pick[k] = 1'b1;
                k++;
            end
        end
        for (int l = 0; l < `RN_FETCH_W; l++) begin
            needs[l] = dec_group[l].valid && dec_group[l].rd_valid && dec_group[l].rd != '0;
            lanes += int'(dec_group[l].valid);
        end
        exp_ready = ((needs & ~has_pick) == '0) && (credits >= lanes);
    end

    // ==================================================================
    // Shadow update, lanes renamed one after another in program order
    // ==================================================================
    always @(posedge clk or posedge reset) begin : update
        rename_pkg::phys_reg_t [`RN_ARCH_REGS-1:0] m;
        logic [`RN_PHYS_REGS-1:0]                  f;
        rename_pkg::ren_group_t                    g;
        rename_pkg::dec_uop_t                      u;
        logic                                      fire;
        if (reset) begin
            for (int i = 0; i < `RN_ARCH_REGS; i++) begin
                shadow_map[i] <= rename_pkg::phys_reg_t'(i);
            end
            for (int i = 0; i < `RN_PHYS_REGS; i++) begin
                shadow_free[i] <= (i >= `RN_ARCH_REGS);
            end
            credits   <= `RN_IQ_CREDITS;
            in_flight <= 0;
        end else begin
            fire = dec_in_valid && exp_ready;
            m    = shadow_map;
            f    = shadow_free;
            for (int l = 0; l < `RN_FETCH_W; l++) begin
                u               = dec_group[l];
                g[l]            = '0;
                g[l].valid      = u.valid;
                g[l].opcode     = u.opcode;
                g[l].alu_func   = u.alu_func;
                g[l].imm        = u.imm;
                g[l].pc         = u.pc;
                g[l].is_alu     = u.is_alu;
                g[l].is_load    = u.is_load;
                g[l].is_store   = u.is_store;
                g[l].is_branch  = u.is_branch;
                g[l].is_cas     = u.is_cas;
                g[l].arch_rd    = u.rd;
                g[l].prs1_valid = u.rs1_valid;
                g[l].prs2_valid = u.rs2_valid;
                // x0 and unused operands read as 0
                g[l].prs1       = (u.rs1_valid && u.rs1 != '0) ? m[u.rs1] : '0;
                g[l].prs2       = (u.rs2_valid && u.rs2 != '0) ? m[u.rs2] : '0;
                g[l].prd_valid  = needs[l];
                if (needs[l]) begin
                    g[l].prd     = pick[l];
                    g[l].old_prd = m[u.rd];
                    // Later lanes see this mapping
                    m[u.rd]      = pick[l];
                    f[pick[l]]   = 1'b0;
                end
            end
            if (fire) begin
                shadow_map <= m;
                exp_group  <= g;
            end else begin
                f = shadow_free;
            end
            if (commit.valid && commit.old_prd != '0) begin
                f[commit.old_prd] = 1'b1;
            end
            shadow_free <= f;
            credits     <= credits - (fire ? lanes : 0) + int'(credit_return);
            in_flight   <= in_flight + (ren_out_valid ? count_sent(ren_group) : 0)
                           - int'(credit_return);
        end
    end

    // ==================================================================
    // Checks
    // ==================================================================
    a_ready: assert property (@(posedge clk) disable iff (reset) dec_ready == exp_ready)
        else begin
            errors++;
            $display("mismatch at %0t: dec_ready %0b, expected %0b",
                     $time, $sampled(dec_ready), $sampled(exp_ready));
        end

    a_pulse: assert property (@(posedge clk) disable iff (reset)
        (dec_in_valid && dec_ready) |=> ren_out_valid)
        else begin
            errors++;
            $display("At %0t an accepted group gave no output pulse one cycle later", $time);
        end

    a_quiet: assert property (@(posedge clk) disable iff (reset)
        !(dec_in_valid && dec_ready) |=> !ren_out_valid)
        else begin
            errors++;
            $display("At %0t an output pulse came without an accepted group", $time);
        end

    a_group: assert property (@(posedge clk) disable iff (reset)
        ren_out_valid |-> ren_group == exp_group)
        else begin
            errors++;
            $display("mismatch at %0t: ren_group %h, expected %h",
                     $time, $sampled(ren_group), $sampled(exp_group));
        end

    a_free: assert property (@(posedge clk) disable iff (reset)
        free_count == $countones(shadow_free))
        else begin
            errors++;
            $display("mismatch at %0t: free_count %0d, expected %0d",
                     $time, $sampled(free_count), $countones($sampled(shadow_free)));
        end

    // Issue queue never holds more than its entries
    a_in_flight: assert property (@(posedge clk) disable iff (reset)
        in_flight <= `RN_IQ_CREDITS)
        else begin
            errors++;
            $display("At %0t more instructions are in flight than the issue queue holds", $time);
        end

endmodule

/* test/tb_rename_unit.sv */
`timescale 1ns/1ps
`include "rename_defs.svh"

module tb_rename_unit;

    localparam int RAND_GROUPS = 300;
    // Directed part plus a few cycles per random group
    localparam int TEST_CYCLES = 200 + RAND_GROUPS * 4;
    localparam int MAX_WAIT    = 60;

    logic                        clk;
    logic                        reset;
    rename_pkg::dec_group_t      dec_group;
    logic                        dec_in_valid;
    logic                        dec_ready;
    rename_pkg::ren_group_t      ren_group;
    logic                        ren_out_valid;
    logic [`RN_GROUP_CNT_W-1:0]  credit_return;
    rename_pkg::commit_t         commit;
    logic [`RN_FREE_CNT_W-1:0]   free_count;

    int model_errors;
    int stuck = 0;
    int seed;
    // Lanes received by the issue queue and not yet returned
    int issued = 0;
    // 0 holds credits, 1 returns all it can, 2 returns a random amount
    int credit_mode;
    // 0 no commits, 1 random commits, 2 commit every cycle
    int commit_mode;
    rename_pkg::phys_reg_t retire_q[$];

    rename_unit dut0 (.*);
    rename_model model0 (.*, .errors(model_errors));

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        #((TEST_CYCLES + 100) * 20);
        $display("Watchdog expired before the stimulus finished");
        $display("SOME TESTS FAILED");
        $finish;
    end

    // Issue queue side sampled mid-cycle
    always @(negedge clk) begin
        if (!reset && ren_out_valid) begin
            for (int l = 0; l < `RN_FETCH_W; l++) begin
                if (ren_group[l].valid) begin
                    issued++;
                    // Retirement frees the replaced mapping in program order
                    if (ren_group[l].prd_valid)
                        retire_q.push_back(ren_group[l].old_prd);
                end
            end
        end
    end

    // ==================================================================
    // Stimulus helpers
    // ==================================================================
    function automatic rename_pkg::dec_uop_t make_uop(input logic v,
            input rename_pkg::arch_reg_t rs1, input rename_pkg::arch_reg_t rs2,
            input rename_pkg::arch_reg_t rd, input logic rdv);
        rename_pkg::dec_uop_t u;
        u           = '0;
        u.valid     = v;
        u.opcode    = 6'($random(seed));
        u.alu_func  = 6'($random(seed));
        u.rs1       = rs1;
        u.rs1_valid = 1'b1;
        u.rs2       = rs2;
        u.rs2_valid = (rs2 != '0);
        u.rd        = rd;
        u.rd_valid  = rdv;
        u.imm       = $random(seed);
        u.pc        = $random(seed) & 32'hffff_fffc;
        {u.is_alu, u.is_load, u.is_store, u.is_branch, u.is_cas} = 5'($random(seed));
        return u;
    endfunction

    function automatic rename_pkg::dec_group_t make_group(input rename_pkg::dec_uop_t a,
            input rename_pkg::dec_uop_t b);
        rename_pkg::dec_group_t g;
        g[0] = a;
        g[1] = b;
        return g;
    endfunction

    function automatic rename_pkg::dec_group_t random_group();
        rename_pkg::dec_group_t g;
        for (int l = 0; l < `RN_FETCH_W; l++) begin
            g[l] = make_uop(($random(seed) & 7) != 0, 5'($random(seed)), 5'($random(seed)),
                            5'($random(seed)), ($random(seed) & 3) != 0);
        end
        return g;
    endfunction

    // One cycle from just after an edge with credits and commits by mode
    task automatic drive_cycle(input rename_pkg::dec_group_t g, input logic v,
            output logic took);
        int cr;
        cr     = 0;
        commit = '0;
        if (credit_mode == 1) begin
            cr = (issued < `RN_FETCH_W) ? issued : `RN_FETCH_W;
        end else if (credit_mode == 2) begin
            cr = ($random(seed) & 32'h7fff_ffff) % (`RN_FETCH_W + 1);
            if (cr > issued)
                cr = issued;
        end
        issued -= cr;
        if (retire_q.size() > 0
            && (commit_mode == 2 || (commit_mode == 1 && ($random(seed) & 1) == 0))) begin
            commit.valid   = 1'b1;
            commit.old_prd = retire_q.pop_front();
        end
        dec_group     = g;
        dec_in_valid  = v;
        credit_return = `RN_GROUP_CNT_W'(cr);
        #16;
        took = v && dec_ready;
        @(posedge clk);
        #2;
        dec_in_valid  = 1'b0;
        commit        = '0;
        credit_return = '0;
    endtask

    // Holds the group until it transfers
    task automatic send(input rename_pkg::dec_group_t g);
        logic took;
        int   tries;
        took  = 1'b0;
        tries = 0;
        while (!took && tries < MAX_WAIT) begin
            drive_cycle(g, 1'b1, took);
            tries++;
        end
        if (!took) begin
            stuck++;
            $display("Group was not accepted within %0d cycles at %0t", MAX_WAIT, $time);
        end
    endtask

    task automatic idle(input int n);
        logic took;
        repeat (n) drive_cycle('0, 1'b0, took);
    endtask

    // ==================================================================
    // Main sequence
    // ==================================================================
    initial begin
        rename_pkg::dec_group_t g;
        logic took;
        int   k;
        seed          = 32'heb655fe5;
        reset         = 1'b1;
        dec_group     = '0;
        dec_in_valid  = 1'b0;
        credit_return = '0;
        commit        = '0;
        credit_mode   = 1;
        commit_mode   = 0;
        repeat (8) @(posedge clk);
        #2;
        reset = 1'b0;
        idle(3);

        // No destinations so sources read the identity map and x0
        send(make_group(make_uop(1, 0, 3, 0, 0), make_uop(1, 31, 7, 12, 0)));
        send(make_group(make_uop(1, 1, 2, 0, 1), make_uop(0, 4, 5, 6, 1)));

        // Allocation in lane order and then old_prd from the new map
        send(make_group(make_uop(1, 1, 2, 5, 1), make_uop(1, 5, 3, 6, 1)));
        send(make_group(make_uop(1, 5, 6, 5, 1), make_uop(1, 7, 8, 0, 1)));

        // Same rd in both lanes with lane 1 reading it too
        send(make_group(make_uop(1, 2, 3, 9, 1), make_uop(1, 9, 9, 9, 1)));
        send(make_group(make_uop(1, 9, 9, 10, 1), make_uop(1, 10, 0, 11, 0)));
        idle(2);

        // ==============================================================
        // Free list exhaustion and refill through commit
        // ==============================================================
        g = make_group(make_uop(1, 4, 5, 12, 1), make_uop(1, 12, 1, 0, 0));
        k = 0;
        while (free_count != 0 && k < 40) begin
            send(g);
            k++;
        end
        repeat (4) drive_cycle(g, 1'b1, took);
        commit_mode = 2;
        send(g);
        commit_mode = 0;
        idle(2);

        // Credits run out after a full issue queue
        k = 0;
        while (issued != 0 && k < 20) begin
            idle(1);
            k++;
        end
        credit_mode = 0;
        g = make_group(make_uop(1, 1, 2, 0, 0), make_uop(1, 3, 4, 0, 0));
        repeat (`RN_IQ_CREDITS / `RN_FETCH_W) send(g);
        repeat (5) drive_cycle(g, 1'b1, took);
        credit_mode = 1;
        send(g);

        // Random mix
        credit_mode = 2;
        commit_mode = 1;
        for (k = 0; k < RAND_GROUPS; k++) begin
            send(random_group());
        end
        credit_mode = 1;
        commit_mode = 0;
        idle(4);

        $display("Errors: %0d from checks, %0d stalled groups", model_errors, stuck);
        if (model_errors == 0 && stuck == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* all.f */
+incdir+logic
logic/rename_pkg.sv
logic/free_list.sv
logic/rename_table.sv
logic/rename_stage.sv
logic/rename_unit.sv
test/rename_model.sv
test/tb_rename_unit.sv

/* Bender.yml */
package:
  name: rename_unit

export_include_dirs:
  - logic

sources:
  - files:
      - logic/rename_pkg.sv
      - logic/free_list.sv
      - logic/rename_table.sv
      - logic/rename_stage.sv
      - logic/rename_unit.sv
  - target: test
    files:
      - test/rename_model.sv
      - test/tb_rename_unit.sv
